// File: verilog/ahb_pkg.sv
`default_nettype none

package ahb_pkg;

    localparam int haddr_width = 4;
    localparam int hdata_width = 16;

    typedef enum logic [1:0] {
        htrans_idle   = 2'b00,
        htrans_busy   = 2'b01,
        htrans_nonseq = 2'b10,
        htrans_seq    = 2'b11
    } htrans_t;

    typedef enum logic {
        hsize_byte     = 1'b0,
        hsize_halfword = 1'b1
    } hsize_t;

    localparam logic [haddr_width-1:0] addr_status_lo = 4'd0;
    localparam logic [haddr_width-1:0] addr_status_hi = 4'd1;
    localparam logic [haddr_width-1:0] addr_result_lo = 4'd2;
    localparam logic [haddr_width-1:0] addr_result_hi = 4'd3;
    localparam logic [haddr_width-1:0] addr_sample_lo = 4'd4;
    localparam logic [haddr_width-1:0] addr_sample_hi = 4'd5;

    // Coefficient k sits at 6+2k and 7+2k.
    localparam logic [haddr_width-1:0] addr_coeff_base = 4'd6;

    localparam logic [haddr_width-1:0] addr_new_coeff = 4'd14;
    localparam logic [haddr_width-1:0] addr_reserved  = 4'd15;

endpackage

`default_nettype wire

// File: verilog/fir_pkg.sv
`default_nettype none

package fir_pkg;

    localparam int data_width        = 16;
    localparam int num_taps          = 4;
    localparam int coeff_index_width = 2;
    localparam int acc_width         = 34;
    localparam int frac_bits         = 15;

    localparam int status_busy_bit  = 0;
    localparam int status_error_bit = 8;

    typedef enum logic [1:0] {
        fir_idle    = 2'b00,
        fir_shift   = 2'b01,
        fir_mac     = 2'b10,
        fir_publish = 2'b11
    } fir_state_t;

    typedef enum logic [1:0] {
        loader_idle  = 2'b00,
        loader_load  = 2'b01,
        loader_clear = 2'b10
    } loader_state_t;

endpackage

`default_nettype wire

// File: verilog/ahb_lite_slave.sv
`timescale 1ns/100ps
`default_nettype none

module ahb_lite_slave
    import ahb_pkg::*;
    import fir_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          hsel,
    input  wire  [haddr_width-1:0]       haddr,
    input  wire                          hsize,
    input  wire  [1:0]                   htrans,
    input  wire                          hwrite,
    input  wire  [hdata_width-1:0]       hwdata,
    output logic [hdata_width-1:0]       hrdata,
    output logic                         hresp,
    input  wire  [coeff_index_width-1:0] coefficient_num,
    input  wire                          clear_coeff_set,
    input  wire                          modwait,
    input  wire  [data_width-1:0]        fir_out,
    input  wire                          err,
    output logic [data_width-1:0]        sample_data,
    output logic                         data_ready,
    output logic                         new_coefficient_set,
    output logic [data_width-1:0]        fir_coefficient
);

    logic [data_width-1:0]        coeff_regs [num_taps];
    logic                         accept;
    logic                         bad_access;
    logic [haddr_width-1:0]       rd_offset;
    logic [haddr_width-1:0]       wr_offset;
    logic [hdata_width-1:0]       status_word;
    logic [hdata_width-1:0]       rd_word;
    logic [hdata_width-1:0]       rd_lane;
    logic                         dp_write;
    logic [haddr_width-1:0]       dp_addr;
    hsize_t                       dp_size;

    // Keeps the untouched byte of a register on a byte write.
    function automatic logic [hdata_width-1:0] lane_merge(
        input logic [hdata_width-1:0] old_word,
        input logic [hdata_width-1:0] new_word,
        input hsize_t                 size,
        input logic                   odd
    );
        logic [hdata_width-1:0] merged;
        merged = new_word;
        if (size == hsize_byte) begin
            if (odd) begin
                merged[7:0] = old_word[7:0];
            end else begin
                merged[hdata_width-1:8] = old_word[hdata_width-1:8];
            end
        end
        return merged;
    endfunction

    assign accept = hsel && (htrans == htrans_nonseq || htrans == htrans_seq);
    assign bad_access = accept && ((hwrite && haddr <= addr_result_hi) || haddr == addr_reserved);

    assign rd_offset = haddr - addr_coeff_base;
    assign wr_offset = dp_addr - addr_coeff_base;
    assign fir_coefficient = coeff_regs[coefficient_num];

    always_comb begin
        status_word = '0;
        status_word[status_busy_bit] = new_coefficient_set | modwait;
        status_word[status_error_bit] = err;
    end

    always_comb begin
        case (haddr)
            addr_status_lo, addr_status_hi: rd_word = status_word;
            addr_result_lo, addr_result_hi: rd_word = fir_out;
            addr_sample_lo, addr_sample_hi: rd_word = sample_data;
            addr_new_coeff:                 rd_word = hdata_width'(new_coefficient_set);
            addr_reserved:                  rd_word = '0;
            default:                        rd_word = coeff_regs[rd_offset[coeff_index_width:1]];
        endcase
        rd_lane = rd_word;
        if (hsize == hsize_byte) begin
            if (haddr[0]) begin
                rd_lane = {rd_word[hdata_width-1:8], 8'h00};  // High byte stays in its lane.
            end else begin
                rd_lane = {8'h00, rd_word[7:0]};
            end
        end
    end

    always_ff @(posedge clk) begin
        dp_addr <= haddr;
        dp_size <= hsize_t'(hsize);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hrdata              <= '0;
            hresp               <= 1'b0;
            dp_write            <= 1'b0;
            data_ready          <= 1'b0;
            new_coefficient_set <= 1'b0;
            sample_data         <= '0;
            for (int i = 0; i < num_taps; i++) begin
                coeff_regs[i] <= '0;
            end
        end else begin
            hresp    <= bad_access;
            hrdata   <= (accept && !hwrite && !bad_access) ? rd_lane : '0;
            dp_write <= accept && hwrite && !bad_access;
            data_ready <= dp_write && dp_size == hsize_halfword &&
                          (dp_addr == addr_sample_lo || dp_addr == addr_sample_hi);
            if (clear_coeff_set) begin
                new_coefficient_set <= 1'b0;
            end
            if (dp_write) begin
                case (dp_addr)
                    addr_sample_lo, addr_sample_hi: begin
                        sample_data <= lane_merge(sample_data, hwdata, dp_size, dp_addr[0]);
                    end
                    addr_new_coeff: begin
                        new_coefficient_set <= hwdata[0];  // Bus set wins over the clear.
                    end
                    default: begin
                        coeff_regs[wr_offset[coeff_index_width:1]] <= lane_merge(
                            coeff_regs[wr_offset[coeff_index_width:1]],
                            hwdata, dp_size, dp_addr[0]);
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/coefficient_loader.sv
`timescale 1ns/100ps
`default_nettype none

module coefficient_loader
    import fir_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          new_coefficient_set,
    input  wire                          modwait,
    output logic [coeff_index_width-1:0] coefficient_num,
    output logic                         load_coeff,
    output logic                         loading,
    output logic                         clear_coeff_set
);

    loader_state_t                state;
    logic [coeff_index_width-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= loader_idle;
            count <= '0;
        end else begin
            case (state)
                loader_idle: begin
                    if (new_coefficient_set && !modwait) begin  // Never reload mid-filter.
                        state <= loader_load;
                        count <= '0;
                    end
                end
                loader_load: begin
                    count <= count + 1'b1;
                    if (count == coeff_index_width'(num_taps - 1)) begin
                        state <= loader_clear;
                    end
                end
                loader_clear: begin
                    state <= loader_idle;
                end
                default: begin
                    state <= loader_idle;
                end
            endcase
        end
    end

    assign coefficient_num = count;
    assign loading         = (state == loader_load);
    assign load_coeff      = (state == loader_load);
    assign clear_coeff_set = (state == loader_clear);  // The flag drops one cycle later.

endmodule

`default_nettype wire

// File: verilog/fir_controller.sv
`timescale 1ns/100ps
`default_nettype none

module fir_controller
    import fir_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          data_ready,
    input  wire                          loading,
    output logic                         modwait,
    output logic                         shift_sample,
    output logic                         clear_acc,
    output logic                         mac_en,
    output logic [coeff_index_width-1:0] tap_index,
    output logic                         publish
);

    fir_state_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= fir_idle;
            tap_index <= '0;
        end else begin
            case (state)
                fir_idle: begin
                    if (data_ready && !loading) begin  // A strobe seen while busy is lost.
                        state <= fir_shift;
                    end
                end
                fir_shift: begin
                    tap_index <= '0;
                    state     <= fir_mac;
                end
                fir_mac: begin
                    tap_index <= tap_index + 1'b1;
                    if (tap_index == coeff_index_width'(num_taps - 1)) begin
                        state <= fir_publish;
                    end
                end
                fir_publish: begin
                    state <= fir_idle;
                end
                default: begin
                    state <= fir_idle;
                end
            endcase
        end
    end

    // Shift and clear share one cycle, so a sample takes six busy cycles.
    assign modwait      = (state != fir_idle);
    assign shift_sample = (state == fir_shift);
    assign clear_acc    = (state == fir_shift);
    assign mac_en       = (state == fir_mac);
    assign publish      = (state == fir_publish);

endmodule

`default_nettype wire

// File: verilog/fir_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module fir_datapath
    import fir_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst,
    input  wire  signed [data_width-1:0] sample_data,
    input  wire  signed [data_width-1:0] fir_coefficient,
    input  wire  [coeff_index_width-1:0] coefficient_num,
    input  wire                          load_coeff,
    input  wire                          shift_sample,
    input  wire                          clear_acc,
    input  wire                          mac_en,
    input  wire  [coeff_index_width-1:0] tap_index,
    input  wire                          publish,
    output logic signed [data_width-1:0] fir_out,
    output logic                         err
);

    logic signed [data_width-1:0] taps   [num_taps];
    logic signed [data_width-1:0] coeffs [num_taps];
    logic signed [acc_width-1:0]  acc;
    logic signed [acc_width-1:0]  product;
    logic signed [acc_width-1:0]  shifted;
    logic [acc_width-data_width:0] upper;
    logic                         overflow;
    logic signed [data_width-1:0] saturated;

    assign product = acc_width'(taps[tap_index])
                   * acc_width'(coeffs[tap_index]);  // Sign extended to the accumulator.
    assign shifted = acc >>> frac_bits;

    // The result fits only when every bit above the sign bit matches it.
    assign upper    = shifted[acc_width-1:data_width-1];
    assign overflow = !((&upper) || !(|upper));

    always_comb begin
        saturated = shifted[data_width-1:0];
        if (overflow) begin
            saturated = shifted[acc_width-1] ? {1'b1, {(data_width-1){1'b0}}}
                                             : {1'b0, {(data_width-1){1'b1}}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc     <= '0;
            fir_out <= '0;
            err     <= 1'b0;
            for (int i = 0; i < num_taps; i++) begin
                taps[i]   <= '0;
                coeffs[i] <= '0;
            end
        end else begin
            if (shift_sample) begin
                taps[0] <= sample_data;  // Newest sample is tap 0.
                for (int i = 1; i < num_taps; i++) begin
                    taps[i] <= taps[i-1];
                end
            end
            if (load_coeff) begin
                coeffs[coefficient_num] <= fir_coefficient;
            end
            if (clear_acc) begin
                acc <= '0;
            end else if (mac_en) begin
                acc <= acc + product;
            end
            if (publish) begin
                fir_out <= saturated;
                err     <= overflow;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/ahb_lite_fir_filter.sv
`timescale 1ns/100ps
`default_nettype none

module ahb_lite_fir_filter
    import ahb_pkg::*;
    import fir_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    hsel,
    input  wire  [haddr_width-1:0] haddr,
    input  wire                    hsize,
    input  wire  [1:0]             htrans,
    input  wire                    hwrite,
    input  wire  [hdata_width-1:0] hwdata,
    output logic [hdata_width-1:0] hrdata,
    output logic                   hresp
);

    logic [data_width-1:0]        sample_data;
    logic [data_width-1:0]        fir_coefficient;
    logic [data_width-1:0]        fir_out;
    logic [coeff_index_width-1:0] coefficient_num;
    logic [coeff_index_width-1:0] tap_index;
    logic                         data_ready;
    logic                         new_coefficient_set;
    logic                         clear_coeff_set;
    logic                         load_coeff;
    logic                         loading;
    logic                         modwait;
    logic                         shift_sample;
    logic                         clear_acc;
    logic                         mac_en;
    logic                         publish;
    logic                         err;

    ahb_lite_slave ahb_lite_slave_i (
        .clk(clk), .rst(rst),
        .hsel(hsel), .haddr(haddr), .hsize(hsize), .htrans(htrans),
        .hwrite(hwrite), .hwdata(hwdata), .hrdata(hrdata), .hresp(hresp),
        .coefficient_num(coefficient_num), .clear_coeff_set(clear_coeff_set),
        .modwait(modwait), .fir_out(fir_out), .err(err),
        .sample_data(sample_data), .data_ready(data_ready),
        .new_coefficient_set(new_coefficient_set), .fir_coefficient(fir_coefficient)
    );

    coefficient_loader coefficient_loader_i (
        .clk(clk), .rst(rst),
        .new_coefficient_set(new_coefficient_set), .modwait(modwait),
        .coefficient_num(coefficient_num), .load_coeff(load_coeff),
        .loading(loading), .clear_coeff_set(clear_coeff_set)
    );

    fir_controller fir_controller_i (
        .clk(clk), .rst(rst),
        .data_ready(data_ready), .loading(loading), .modwait(modwait),
        .shift_sample(shift_sample), .clear_acc(clear_acc), .mac_en(mac_en),
        .tap_index(tap_index), .publish(publish)
    );

    fir_datapath fir_datapath_i (
        .clk(clk), .rst(rst),
        .sample_data(sample_data), .fir_coefficient(fir_coefficient),
        .coefficient_num(coefficient_num), .load_coeff(load_coeff),
        .shift_sample(shift_sample), .clear_acc(clear_acc), .mac_en(mac_en),
        .tap_index(tap_index), .publish(publish), .fir_out(fir_out), .err(err)
    );

endmodule

`default_nettype wire

// File: verif/tb_ahb_bus_tasks.svh
`ifndef TB_AHB_BUS_TASKS_SVH
`define TB_AHB_BUS_TASKS_SVH

// Single AHB-Lite write: address phase, then data phase with hwdata.
task automatic bus_write(
    input  logic [haddr_width-1:0] addr,
    input  logic                   size,
    input  logic [hdata_width-1:0] data,
    output logic                   resp
);
    @(negedge clk);
    hsel   = 1'b1;
    haddr  = addr;
    hsize  = size;
    htrans = htrans_nonseq;
    hwrite = 1'b1;
    @(negedge clk);
    hsel   = 1'b0;
    htrans = htrans_idle;
    hwrite = 1'b0;
    hwdata = data;
    resp   = hresp;  // Error response is a level in the data phase.
    @(negedge clk);
endtask

// Single AHB-Lite read, sampled in the middle of the data phase.
task automatic bus_read(
    input  logic [haddr_width-1:0] addr,
    input  logic                   size,
    output logic [hdata_width-1:0] data,
    output logic                   resp
);
    @(negedge clk);
    hsel   = 1'b1;
    haddr  = addr;
    hsize  = size;
    htrans = htrans_nonseq;
    hwrite = 1'b0;
    @(negedge clk);
    hsel   = 1'b0;
    htrans = htrans_idle;
    data   = hrdata;
    resp   = hresp;
endtask

// Reference filter: newest sample at tap 0.
logic signed [15:0] model_taps   [4];
logic signed [15:0] model_coeffs [4];

task automatic model_push(input logic signed [15:0] sample);
    for (int i = 3; i > 0; i--) begin
        model_taps[i] = model_taps[i-1];
    end
    model_taps[0] = sample;
endtask

function automatic logic [15:0] model_result(output logic ovf);
    longint sum;
    longint scaled;
    sum = 0;
    for (int i = 0; i < 4; i++) begin
        sum += longint'(model_taps[i]) * longint'(model_coeffs[i]);
    end
    scaled = sum >>> 15;
    ovf = 1'b1;
    if (scaled > 32767) begin
        return 16'h7fff;
    end
    if (scaled < -32768) begin
        return 16'h8000;
    end
    ovf = 1'b0;
    return scaled[15:0];
endfunction

`endif

// File: verif/tb_ahb_lite_fir_filter.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ahb_lite_fir_filter
    import ahb_pkg::*;
    import fir_pkg::*;
;

    localparam int max_cycles = 4000;

    logic                   clk;
    logic                   rst;
    logic                   hsel;
    logic [haddr_width-1:0] haddr;
    logic                   hsize;
    logic [1:0]             htrans;
    logic                   hwrite;
    logic [hdata_width-1:0] hwdata;
    logic [hdata_width-1:0] hrdata;
    logic                   hresp;
    int                     cycles;
    int                     seed;

    `include "tb_ahb_bus_tasks.svh"

    ahb_lite_fir_filter ahb_lite_fir_filter_i (
        .clk(clk), .rst(rst), .hsel(hsel), .haddr(haddr), .hsize(hsize),
        .htrans(htrans), .hwrite(hwrite), .hwdata(hwdata),
        .hrdata(hrdata), .hresp(hresp)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Run did not finish within %0d cycles.", max_cycles);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "check failed");
    endtask

    // An error response is a level for the data phase only.
    hresp_single: assert property (@(posedge clk) disable iff (rst) hresp |=> !hresp)
        else report_failure("hresp stayed high for more than one cycle");

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp)
            else report_failure($sformatf("error %s: expected %h, got %h", name, exp, got));
    endtask

    task automatic check_resp(input logic got, input logic exp);
        assert (got === exp)
            else report_failure($sformatf("error hresp: expected %h, got %h", exp, got));
    endtask

    function automatic logic [haddr_width-1:0] coeff_addr(input int k, input int high);
        return haddr_width'(int'(addr_coeff_base) + 2 * k + high);
    endfunction

    // Polls status; with saw_needed, busy must be seen set before it counts as clear.
    task automatic wait_not_busy(input bit saw_needed);
        logic [15:0] data;
        logic        resp;
        bit          seen;
        bit          done;
        seen = 0;
        done = 0;
        for (int n = 0; n < 20 && !done; n++) begin
            bus_read(addr_status_lo, hsize_halfword, data, resp);
            if (data[status_busy_bit]) begin
                seen = 1;
            end else if (seen || !saw_needed) begin
                done = 1;
            end
        end
        assert (done) else report_failure("Status busy never cleared.");
    endtask

    task automatic load_coefficients();
        logic resp;
        int   start;
        for (int k = 0; k < 4; k++) begin
            bus_write(coeff_addr(k, 0), hsize_halfword, model_coeffs[k], resp);
            check_resp(resp, 1'b0);
        end
        bus_write(addr_new_coeff, hsize_halfword, 16'h0001, resp);
        start = cycles;
        wait_not_busy(0);
        assert (cycles - start <= 10)
            else report_failure("Coefficient load kept status busy too long.");
    endtask

    task automatic run_sample(input logic [15:0] sample);
        logic [15:0] data;
        logic [15:0] exp;
        logic        resp;
        logic        ovf;
        bus_write(addr_sample_lo, hsize_halfword, sample, resp);
        check_resp(resp, 1'b0);
        model_push(sample);
        exp = model_result(ovf);
        wait_not_busy(1);
        bus_read(addr_result_lo, hsize_halfword, data, resp);
        check_value("result", data, exp);
        bus_read(addr_status_lo, hsize_halfword, data, resp);
        check_value("status", data, {7'b0, ovf, 8'b0});
    endtask

    initial begin
        logic [15:0]        data;
        logic [15:0]        exp;
        logic               resp;
        logic               ovf;
        logic signed [12:0] small_coeff;

        clk    = 1'b0;
        rst    = 1'b1;
        hsel   = 1'b0;
        haddr  = '0;
        hsize  = hsize_halfword;
        htrans = htrans_idle;
        hwrite = 1'b0;
        hwdata = '0;
        cycles = 0;
        seed   = 32'h99ac_d9fa;
        for (int i = 0; i < 4; i++) begin
            model_taps[i]   = '0;
            model_coeffs[i] = '0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // Reset values.
        bus_read(addr_status_lo, hsize_halfword, data, resp);
        check_value("status", data, 16'h0000);
        check_resp(resp, 1'b0);
        bus_read(addr_result_lo, hsize_halfword, data, resp);
        check_value("result", data, 16'h0000);
        check_resp(resp, 1'b0);
        for (int k = 0; k < 4; k++) begin
            bus_read(coeff_addr(k, 0), hsize_halfword, data, resp);
            check_value("coefficient", data, 16'h0000);
            check_resp(resp, 1'b0);
        end

        // Readback with byte lanes.
        bus_write(coeff_addr(0, 0), hsize_halfword, 16'h1234, resp);
        bus_read(coeff_addr(0, 0), hsize_halfword, data, resp);
        check_value("coefficient", data, 16'h1234);
        bus_write(coeff_addr(0, 1), hsize_byte, 16'hab00, resp);
        bus_read(coeff_addr(0, 0), hsize_halfword, data, resp);
        check_value("coefficient", data, 16'hab34);
        bus_write(coeff_addr(1, 0), hsize_halfword, 16'h5678, resp);
        bus_write(coeff_addr(1, 0), hsize_byte, 16'h00cd, resp);
        bus_read(coeff_addr(1, 1), hsize_halfword, data, resp);
        check_value("coefficient", data, 16'h56cd);
        bus_read(coeff_addr(1, 1), hsize_byte, data, resp);
        check_value("coefficient", data, 16'h5600);

        // Error responses leave everything as it was.
        for (int a = 0; a < 4; a++) begin
            bus_write(haddr_width'(a), hsize_halfword, 16'hffff, resp);
            check_resp(resp, 1'b1);
        end
        bus_write(addr_reserved, hsize_halfword, 16'hffff, resp);
        check_resp(resp, 1'b1);
        bus_read(addr_reserved, hsize_halfword, data, resp);
        check_resp(resp, 1'b1);
        check_value("hrdata", data, 16'h0000);
        bus_read(addr_status_lo, hsize_halfword, data, resp);
        check_value("status", data, 16'h0000);
        bus_read(addr_result_lo, hsize_halfword, data, resp);
        check_value("result", data, 16'h0000);
        bus_read(coeff_addr(0, 0), hsize_halfword, data, resp);
        check_value("coefficient", data, 16'hab34);
        bus_read(coeff_addr(1, 0), hsize_halfword, data, resp);
        check_value("coefficient", data, 16'h56cd);
        for (int k = 2; k < 4; k++) begin
            bus_read(coeff_addr(k, 0), hsize_halfword, data, resp);
            check_value("coefficient", data, 16'h0000);
        end

        // Random samples with small coefficients stay in range.
        for (int k = 0; k < 4; k++) begin
            small_coeff = 13'($random(seed));
            model_coeffs[k] = {{3{small_coeff[12]}}, small_coeff};
        end
        load_coefficients();
        for (int n = 0; n < 30; n++) begin
            run_sample(16'($random(seed)));
        end

        // Saturation, then four small samples flush it out.
        for (int k = 0; k < 4; k++) begin
            model_coeffs[k] = 16'h7fff;
        end
        load_coefficients();
        for (int n = 0; n < 4; n++) begin
            run_sample(16'h7fff);
        end
        bus_read(addr_status_lo, hsize_halfword, data, resp);
        assert (data[status_error_bit]) else report_failure("Saturation did not set error.");
        for (int n = 0; n < 4; n++) begin
            run_sample(16'h0001 + 16'(n));
        end

        // Byte reads of the result.
        run_sample(16'h4321);
        exp = model_result(ovf);
        bus_read(addr_result_lo, hsize_byte, data, resp);
        check_value("hrdata", data, {8'h00, exp[7:0]});
        bus_read(addr_result_hi, hsize_byte, data, resp);
        check_value("hrdata", data, {exp[15:8], 8'h00});

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verif
verilog/ahb_pkg.sv
verilog/fir_pkg.sv
verilog/ahb_lite_slave.sv
verilog/coefficient_loader.sv
verilog/fir_controller.sv
verilog/fir_datapath.sv
verilog/ahb_lite_fir_filter.sv
verif/tb_ahb_lite_fir_filter.sv

// File: Makefile
TOP := tb_ahb_lite_fir_filter

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
